//--- Bender.yml
package:
  name: rv_ex

sources:
  - common/ex_pkg.sv
  - ex_stage/ex_alu.sv
  - ex_stage/ex_branch_unit.sv
  - ex_stage/ex_stage.sv
  - src/wb_stage.sv
  - src/ex_subsys_top.sv
  - target: test
    files:
      - dv/ex_checker.sv
      - dv/ex_tb.sv

//--- common/ex_pkg.sv
`default_nettype none

package ex_pkg;

  ////////////////////////////////////////////////////////////
  // ALU and branch compare operations
  ////////////////////////////////////////////////////////////

  // Arithmetic, logic, shift and set-less-than codes come first
  // The compare codes only drive the single compare bit that branches use
  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_AND  = 5'd2,
    ALU_OR   = 5'd3,
    ALU_XOR  = 5'd4,
    ALU_SLL  = 5'd5,
    ALU_SRL  = 5'd6,
    ALU_SRA  = 5'd7,
    ALU_SLT  = 5'd8,
    ALU_SLTU = 5'd9,
    ALU_EQ   = 5'd16,
    ALU_NE   = 5'd17,
    ALU_LT   = 5'd18,
    ALU_GE   = 5'd19,
    ALU_LTU  = 5'd20,
    ALU_GEU  = 5'd21
  } alu_op_e;

  // Per-instruction flags that travel with the decoded instruction
  typedef struct packed {
    logic branch;
    logic compressed;
    logic dummy;
  } instr_meta_t;

  ////////////////////////////////////////////////////////////
  // Pipeline payloads
  ////////////////////////////////////////////////////////////

  // Decoded instruction handed from ID to EX
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] operand_a;
    logic [31:0] operand_b;
    logic [31:0] branch_imm;
    alu_op_e     alu_op;
    logic        alu_en;
    logic        csr_en;
    logic        lsu_en;
    // For an lsu_en entry, sys_en marks the first half of a split access
    logic        sys_en;
    logic        xif_en;
    logic        xif_accepted;
    logic [11:0] csr_addr;
    logic [4:0]  rd;
    logic        rf_we;
    instr_meta_t instr_meta;
  } id_ex_pipe_t;

  // Write requests handed from EX to WB
  typedef struct packed {
    logic        rf_we;
    logic [4:0]  rd;
    logic [31:0] rf_wdata;
    logic        csr_en;
    logic [11:0] csr_addr;
    logic [31:0] csr_wdata;
    logic        lsu_en;
  } ex_wb_pipe_t;

  // Controller requests towards EX
  typedef struct packed {
    logic halt_ex;
    logic kill_ex;
  } ctrl_fsm_t;

  // Security control bits
  typedef struct packed {
    logic dataindtiming;
  } cpuctrl_t;

  ////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////

  // The implemented CSRs are mstatus, mtvec, mscratch and mhartid
  localparam int unsigned CSR_NUM_IMPL = 4;
  localparam logic [CSR_NUM_IMPL-1:0][11:0] CSR_IMPL_ADDRS = {
    12'hF14, 12'h340, 12'h305, 12'h300
  };

  // Address bits [11:10] equal to this mark a read-only CSR
  localparam logic [1:0] CSR_RO_MARK = 2'b11;

  // Fall-through increments for full and compressed instructions
  localparam logic [31:0] PC_INC_FULL       = 32'd4;
  localparam logic [31:0] PC_INC_COMPRESSED = 32'd2;

endpackage

`default_nettype wire

//--- dv/ex_checker.sv
`timescale 1ns/100ps
`default_nettype none

module ex_checker
  import ex_pkg::*;
(
  input  logic        clk,
  input  logic        reset_i,
  input  logic [31:0] cycle_i,
  input  ctrl_fsm_t   ctrl_fsm_i,
  input  logic        ex_ready_i,
  input  logic        branch_valid_i,
  input  logic        branch_taken_i,
  input  logic [31:0] branch_target_i,
  input  logic        rf_we_i,
  input  logic [4:0]  rf_waddr_i,
  input  logic [31:0] rf_wdata_i,
  input  logic        csr_we_i,
  input  logic [11:0] csr_addr_i,
  input  logic [31:0] csr_wdata_i
);

  ////////////////////////////////////////////////////////////
  // Expected entries, oldest first
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] wdata;
    logic [31:0] accept_cycle;
    logic        check_latency;
  } rf_exp_t;

  typedef struct packed {
    logic [11:0] addr;
    logic [31:0] wdata;
  } csr_exp_t;

  typedef struct packed {
    logic        taken;
    logic [31:0] target;
  } branch_exp_t;

  rf_exp_t     rf_q[$];
  csr_exp_t    csr_q[$];
  branch_exp_t branch_q[$];

  int unsigned check_cnt = 0;
  int unsigned error_cnt = 0;

  task automatic expect_rf(input logic [4:0] rd, input logic [31:0] wdata,
                           input logic [31:0] accept_cycle, input logic check_latency);
    rf_q.push_back('{rd, wdata, accept_cycle, check_latency});
  endtask

  task automatic expect_csr(input logic [11:0] addr, input logic [31:0] wdata);
    csr_q.push_back('{addr, wdata});
  endtask

  task automatic expect_branch(input logic taken, input logic [31:0] target);
    branch_q.push_back('{taken, target});
  endtask

  // Entries still waiting for their write or branch result
  function automatic int pending_count();
    return rf_q.size() + csr_q.size() + branch_q.size();
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_cnt++;
    if (actual !== expected) begin
      error_cnt++;
      $display("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h",
               $time, name, expected, actual);
    end
  endtask

  task automatic note_failure(input string what);
    error_cnt++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  ////////////////////////////////////////////////////////////
  // Port sampling on the rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin : sample_ports
    rf_exp_t     rf_exp;
    csr_exp_t    csr_exp;
    branch_exp_t br_exp;
    if (!reset_i) begin
      // Kill frees EX at once and hides its entry
      if (ctrl_fsm_i.kill_ex) begin
        check_value("ex_ready_o", 32'd1, ex_ready_i);
        check_value("branch_valid_o", 32'd0, branch_valid_i);
      end else if (ctrl_fsm_i.halt_ex) begin
        // WB is always drained before a halt here, so a halt must show no retirement
        check_value("ex_ready_o", 32'd0, ex_ready_i);
        check_value("branch_valid_o", 32'd0, branch_valid_i);
        check_value("rf_we_o", 32'd0, rf_we_i);
        check_value("csr_we_o", 32'd0, csr_we_i);
      end

      if (rf_we_i === 1'b1) begin
        if (rf_q.size() == 0) begin
          note_failure("register file write seen while no write was expected");
        end else begin
          rf_exp = rf_q.pop_front();
          check_value("rf_waddr_o", rf_exp.rd, rf_waddr_i);
          check_value("rf_wdata_o", rf_exp.wdata, rf_wdata_i);
          // Without stall or halt the write shows two edges after acceptance
          if (rf_exp.check_latency) begin
            check_value("rf write cycle", rf_exp.accept_cycle + 32'd2, cycle_i);
          end
        end
      end

      if (csr_we_i === 1'b1) begin
        if (csr_q.size() == 0) begin
          note_failure("CSR write seen while no CSR write was expected");
        end else begin
          csr_exp = csr_q.pop_front();
          check_value("csr_addr_o", csr_exp.addr, csr_addr_i);
          check_value("csr_wdata_o", csr_exp.wdata, csr_wdata_i);
        end
      end

      // A branch can sit in EX for several cycles under back-pressure
      // and leaves when EX is ready again
      if (branch_valid_i === 1'b1) begin
        if (branch_q.size() == 0) begin
          note_failure("branch result seen while no branch was expected");
        end else begin
          br_exp = branch_q[0];
          check_value("branch_taken_o", br_exp.taken, branch_taken_i);
          check_value("branch_target_o", br_exp.target, branch_target_i);
          if (ex_ready_i === 1'b1) begin
            br_exp = branch_q.pop_front();
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- dv/ex_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ex_tb
  import ex_pkg::*;
();

  localparam int          CLK_PERIOD   = 8;
  localparam int          RESET_CYCLES = 8;
  localparam int          NUM_PASSES   = 2;
  localparam int          HALT_CYCLES  = 4;
  localparam int          ROW_BUDGET   = 20;
  localparam logic [7:0]  LFSR_SEED    = 8'd74;
  localparam logic [1:0]  ACT_NONE     = 2'd0;
  localparam logic [1:0]  ACT_HALT     = 2'd1;
  localparam logic [1:0]  ACT_KILL     = 2'd2;

  // One table row holds the instruction, how it is controlled and what it must produce
  typedef struct packed {
    id_ex_pipe_t instr;
    logic        dit;
    logic [1:0]  action;
    logic        exp_rf_we;
    logic [31:0] exp_rf_wdata;
    logic        exp_csr_we;
    logic [31:0] exp_csr_wdata;
    logic        exp_taken;
    logic [31:0] exp_target;
  } row_t;

  logic        clk;
  logic        reset_i;
  logic        id_valid_i;
  id_ex_pipe_t id_ex_pipe_i;
  logic        ex_ready_o;
  ctrl_fsm_t   ctrl_fsm_i;
  cpuctrl_t    cpuctrl_i;
  logic        wb_stall_i;
  logic        branch_valid_o;
  logic        branch_taken_o;
  logic [31:0] branch_target_o;
  logic        rf_we_o;
  logic [4:0]  rf_waddr_o;
  logic [31:0] rf_wdata_o;
  logic        csr_we_o;
  logic [11:0] csr_addr_o;
  logic [31:0] csr_wdata_o;

  row_t        rows[$];
  logic [31:0] cycle_cnt = '0;
  int unsigned timeout_limit = 32'hFFFF_FFFF;
  logic        stall_en;
  logic [7:0]  lfsr_state = LFSR_SEED;

  ex_subsys_top i_ex_subsys_top (
    .clk             (clk),
    .reset_i         (reset_i),
    .id_valid_i      (id_valid_i),
    .id_ex_pipe_i    (id_ex_pipe_i),
    .ex_ready_o      (ex_ready_o),
    .ctrl_fsm_i      (ctrl_fsm_i),
    .cpuctrl_i       (cpuctrl_i),
    .wb_stall_i      (wb_stall_i),
    .branch_valid_o  (branch_valid_o),
    .branch_taken_o  (branch_taken_o),
    .branch_target_o (branch_target_o),
    .rf_we_o         (rf_we_o),
    .rf_waddr_o      (rf_waddr_o),
    .rf_wdata_o      (rf_wdata_o),
    .csr_we_o        (csr_we_o),
    .csr_addr_o      (csr_addr_o),
    .csr_wdata_o     (csr_wdata_o)
  );

  ex_checker i_ex_checker (
    .clk             (clk),
    .reset_i         (reset_i),
    .cycle_i         (cycle_cnt),
    .ctrl_fsm_i      (ctrl_fsm_i),
    .ex_ready_i      (ex_ready_o),
    .branch_valid_i  (branch_valid_o),
    .branch_taken_i  (branch_taken_o),
    .branch_target_i (branch_target_o),
    .rf_we_i         (rf_we_o),
    .rf_waddr_i      (rf_waddr_o),
    .rf_wdata_i      (rf_wdata_o),
    .csr_we_i        (csr_we_o),
    .csr_addr_i      (csr_addr_o),
    .csr_wdata_i     (csr_wdata_o)
  );

  ////////////////////////////////////////////////////////////
  // Clock, cycle count, timeout and stall pattern
  ////////////////////////////////////////////////////////////

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 32'd1;
    if (cycle_cnt >= timeout_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // Fibonacci LFSR over x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] state);
    logic feedback;
    feedback = state[7] ^ state[5] ^ state[4] ^ state[3];
    return {state[6:0], feedback};
  endfunction

  // One LFSR step per cycle gives the one stall bit of that cycle
  always @(negedge clk) begin
    if (stall_en) begin
      lfsr_state = lfsr_next(lfsr_state);
      wb_stall_i = lfsr_state[0];
    end else begin
      wb_stall_i = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Table building
  ////////////////////////////////////////////////////////////

  task automatic add_alu(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                         input logic [4:0] rd, input logic [31:0] result,
                         input logic [1:0] action);
    row_t row;
    row = '0;
    row.instr.alu_op    = op;
    row.instr.operand_a = a;
    row.instr.operand_b = b;
    row.instr.alu_en    = 1'b1;
    row.instr.rd        = rd;
    row.instr.rf_we     = 1'b1;
    row.action          = action;
    row.exp_rf_we       = 1'b1;
    row.exp_rf_wdata    = result;
    rows.push_back(row);
  endtask

  // CSR instructions write operand a to both the CSR and rd
  task automatic add_csr(input logic [11:0] addr, input logic [31:0] data,
                         input logic [4:0] rd, input logic rf_we, input logic xif_acc,
                         input logic exp_csr_we);
    row_t row;
    row = '0;
    row.instr.csr_en       = 1'b1;
    row.instr.csr_addr     = addr;
    row.instr.operand_a    = data;
    row.instr.rd           = rd;
    row.instr.rf_we        = rf_we;
    row.instr.xif_en       = xif_acc;
    row.instr.xif_accepted = xif_acc;
    row.exp_rf_we          = rf_we;
    row.exp_rf_wdata       = data;
    row.exp_csr_we         = exp_csr_we;
    row.exp_csr_wdata      = data;
    rows.push_back(row);
  endtask

  task automatic add_lsu(input logic [31:0] data, input logic [4:0] rd,
                         input logic split_first, input logic exp_rf_we);
    row_t row;
    row = '0;
    row.instr.lsu_en    = 1'b1;
    row.instr.sys_en    = split_first;
    row.instr.operand_a = data;
    row.instr.rd        = rd;
    row.instr.rf_we     = 1'b1;
    row.exp_rf_we       = exp_rf_we;
    row.exp_rf_wdata    = data;
    rows.push_back(row);
  endtask

  // Kind holds the compressed and dummy flags, in that order
  task automatic add_branch(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] pc, input logic [31:0] imm,
                            input logic [1:0] kind, input logic dit, input logic taken,
                            input logic [31:0] target, input logic [1:0] action);
    row_t row;
    row = '0;
    row.instr.alu_op                = op;
    row.instr.operand_a             = a;
    row.instr.operand_b             = b;
    row.instr.pc                    = pc;
    row.instr.branch_imm            = imm;
    row.instr.instr_meta.branch     = 1'b1;
    row.instr.instr_meta.compressed = kind[1];
    row.instr.instr_meta.dummy      = kind[0];
    row.dit                         = dit;
    row.action                      = action;
    row.exp_taken                   = taken;
    row.exp_target                  = target;
    rows.push_back(row);
  endtask

  task automatic build_table();
    // Each ALU operation once
    // Shifts see only the low five bits of operand b
    add_alu(ALU_ADD,  32'h0000_1234, 32'h0000_0F0F, 5'd1,  32'h0000_2143, ACT_NONE);
    add_alu(ALU_SUB,  32'h0000_0010, 32'h0000_0020, 5'd2,  32'hFFFF_FFF0, ACT_NONE);
    add_alu(ALU_AND,  32'hF0F0_F0F0, 32'hFF00_FF00, 5'd3,  32'hF000_F000, ACT_NONE);
    add_alu(ALU_OR,   32'hF0F0_0000, 32'h0000_0F0F, 5'd4,  32'hF0F0_0F0F, ACT_NONE);
    add_alu(ALU_XOR,  32'hAAAA_5555, 32'hFFFF_0000, 5'd5,  32'h5555_5555, ACT_NONE);
    add_alu(ALU_SLL,  32'h0000_0001, 32'h0000_0024, 5'd6,  32'h0000_0010, ACT_NONE);
    add_alu(ALU_SRL,  32'h8000_0000, 32'h0000_0004, 5'd7,  32'h0800_0000, ACT_NONE);
    add_alu(ALU_SRA,  32'h8000_0000, 32'h0000_0004, 5'd8,  32'hF800_0000, ACT_NONE);
    add_alu(ALU_SLT,  32'hFFFF_FFFF, 32'h0000_0001, 5'd9,  32'h0000_0001, ACT_NONE);
    add_alu(ALU_SLTU, 32'hFFFF_FFFF, 32'h0000_0001, 5'd10, 32'h0000_0000, ACT_NONE);
    // Legal, missing, read-only and coprocessor-owned CSRs
    add_csr(12'h305, 32'h0000_0100, 5'd11, 1'b1, 1'b0, 1'b1);
    add_csr(12'h7C0, 32'h0000_0012, 5'd12, 1'b1, 1'b0, 1'b0);
    add_csr(12'hF14, 32'h0000_0013, 5'd13, 1'b0, 1'b0, 1'b0);
    add_csr(12'h340, 32'h0000_0014, 5'd14, 1'b0, 1'b1, 1'b0);
    // Only the second half of a split load writes rd
    add_lsu(32'hDEAD_0001, 5'd15, 1'b1, 1'b0);
    add_lsu(32'hDEAD_0002, 5'd15, 1'b0, 1'b1);
    add_alu(ALU_ADD, 32'd5, 32'd6, 5'd17, 32'h0000_000B, ACT_HALT);
    add_alu(ALU_ADD, 32'd7, 32'd8, 5'd18, 32'h0000_000F, ACT_KILL);
    add_alu(ALU_OR,  32'd1, 32'd2, 5'd19, 32'h0000_0003, ACT_NONE);
    // Normal mode targets are always pc plus immediate
    add_branch(ALU_EQ,  32'd5, 32'd5, 32'h100, 32'h40, 2'b00, 1'b0, 1'b1, 32'h140,
               ACT_NONE);
    add_branch(ALU_NE,  32'd5, 32'd5, 32'h200, 32'hFFFF_FFF0, 2'b00, 1'b0, 1'b0, 32'h1F0,
               ACT_NONE);
    add_branch(ALU_LT,  32'hFFFF_FFFE, 32'd1, 32'h300, 32'h20, 2'b00, 1'b0, 1'b1, 32'h320,
               ACT_NONE);
    add_branch(ALU_GEU, 32'd1, 32'hFFFF_FFFE, 32'h400, 32'h8, 2'b00, 1'b0, 1'b0, 32'h408,
               ACT_NONE);
    // Halt and kill must also hide a branch that sits in EX
    add_branch(ALU_EQ,  32'd9, 32'd9, 32'h900, 32'h4, 2'b00, 1'b0, 1'b1, 32'h904,
               ACT_HALT);
    add_branch(ALU_NE,  32'd9, 32'd3, 32'hA00, 32'h8, 2'b00, 1'b0, 1'b1, 32'hA08,
               ACT_KILL);
    // With data-independent timing the untaken branches fall through
    add_branch(ALU_EQ,  32'd1, 32'd2, 32'h500, 32'h100, 2'b00, 1'b1, 1'b1, 32'h504,
               ACT_NONE);
    add_branch(ALU_NE,  32'd1, 32'd2, 32'h600, 32'h80, 2'b00, 1'b1, 1'b1, 32'h680,
               ACT_NONE);
    add_branch(ALU_LTU, 32'd3, 32'd2, 32'h700, 32'h10, 2'b10, 1'b1, 1'b1, 32'h702,
               ACT_NONE);
    add_branch(ALU_GE,  32'd0, 32'd1, 32'h800, 32'h10, 2'b01, 1'b1, 1'b1, 32'h800,
               ACT_NONE);
  endtask

  ////////////////////////////////////////////////////////////
  // Issue
  ////////////////////////////////////////////////////////////

  task automatic wait_drain();
    while (i_ex_checker.pending_count() != 0) begin
      @(negedge clk);
    end
  endtask

  // Starts and ends on a falling edge
  task automatic issue_row(input row_t row, input logic timed);
    logic [31:0] accept_cycle;
    // The security mode only changes while no branch is in EX
    if (row.dit != cpuctrl_i.dataindtiming) begin
      wait_drain();
      cpuctrl_i.dataindtiming = row.dit;
    end
    if (row.action == ACT_HALT) begin
      wait_drain();
    end
    id_valid_i   = 1'b1;
    id_ex_pipe_i = row.instr;
    @(posedge clk);
    while (ex_ready_o !== 1'b1) begin
      @(posedge clk);
    end
    accept_cycle = cycle_cnt;
    // A killed instruction must leave no trace
    if (row.action != ACT_KILL) begin
      if (row.exp_rf_we) begin
        i_ex_checker.expect_rf(row.instr.rd, row.exp_rf_wdata, accept_cycle,
                               timed && row.action == ACT_NONE);
      end
      if (row.exp_csr_we) begin
        i_ex_checker.expect_csr(row.instr.csr_addr, row.exp_csr_wdata);
      end
      if (row.instr.instr_meta.branch) begin
        i_ex_checker.expect_branch(row.exp_taken, row.exp_target);
      end
    end
    @(negedge clk);
    id_valid_i = 1'b0;
    if (row.action == ACT_KILL) begin
      ctrl_fsm_i.kill_ex = 1'b1;
      @(negedge clk);
      ctrl_fsm_i.kill_ex = 1'b0;
    end else if (row.action == ACT_HALT) begin
      ctrl_fsm_i.halt_ex = 1'b1;
      repeat (HALT_CYCLES) @(negedge clk);
      ctrl_fsm_i.halt_ex = 1'b0;
    end
  endtask

  initial begin
    clk          = 1'b0;
    reset_i      = 1'b1;
    id_valid_i   = 1'b0;
    id_ex_pipe_i = '0;
    ctrl_fsm_i   = '0;
    cpuctrl_i    = '0;
    wb_stall_i   = 1'b0;
    stall_en     = 1'b0;
    build_table();
    timeout_limit = ROW_BUDGET * rows.size() * NUM_PASSES + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;
    // The first pass runs without stall and checks latency
    // The second pass runs under random stall
    for (int pass = 0; pass < NUM_PASSES; pass++) begin
      wait_drain();
      stall_en <= (pass != 0);
      for (int i = 0; i < rows.size(); i++) begin
        issue_row(rows[i], pass == 0);
      end
    end
    wait_drain();
    stall_en <= 1'b0;
    // Idle cycles catch any stray write
    repeat (10) @(negedge clk);
    $display("Checks: %0d, errors: %0d, pending: %0d", i_ex_checker.check_cnt,
             i_ex_checker.error_cnt, i_ex_checker.pending_count());
    if (i_ex_checker.error_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ex_stage/ex_alu.sv
`timescale 1ns/100ps
`default_nettype none

module ex_alu
  import ex_pkg::*;
(
  input  logic [31:0] operand_a_i,
  input  logic [31:0] operand_b_i,
  input  alu_op_e     alu_op_i,
  output logic [31:0] result_o,
  output logic        cmp_result_o
);

  ////////////////////////////////////////////////////////////
  // Shared arithmetic
  ////////////////////////////////////////////////////////////

  // One subtractor serves sub, the less-than tests and equality
  logic [31:0] sum;
  logic [31:0] diff;
  logic        equal;
  logic        less_signed;
  logic        less_unsigned;
  logic [4:0]  shamt;

  assign sum  = operand_a_i + operand_b_i;
  assign diff = operand_a_i - operand_b_i;

  assign equal = (diff == 32'd0);

  // Signed less-than looks at the sign bits first and falls back to the
  // subtraction only when both operands have the same sign
  assign less_signed = (operand_a_i[31] != operand_b_i[31]) ? operand_a_i[31] :
                                                              diff[31];

  assign less_unsigned = (operand_a_i < operand_b_i);

  // Only the low five bits of operand b count as shift amount
  assign shamt = operand_b_i[4:0];

  ////////////////////////////////////////////////////////////
  // Compare bit for branches
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (alu_op_i)
      ALU_EQ:  cmp_result_o = equal;
      ALU_NE:  cmp_result_o = !equal;
      ALU_LT:  cmp_result_o = less_signed;
      ALU_GE:  cmp_result_o = !less_signed;
      ALU_LTU: cmp_result_o = less_unsigned;
      ALU_GEU: cmp_result_o = !less_unsigned;
      // Set-less-than also reports its outcome here
      ALU_SLT:  cmp_result_o = less_signed;
      ALU_SLTU: cmp_result_o = less_unsigned;
      default: cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (alu_op_i)
      ALU_ADD:  result_o = sum;
      ALU_SUB:  result_o = diff;
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:  result_o = operand_a_i << shamt;
      ALU_SRL:  result_o = operand_a_i >> shamt;
      ALU_SRA:  result_o = $unsigned($signed(operand_a_i) >>> shamt);
      ALU_SLT:  result_o = {31'd0, less_signed};
      ALU_SLTU: result_o = {31'd0, less_unsigned};
      // Compare codes give the compare bit zero-extended
      default:  result_o = {31'd0, cmp_result_o};
    endcase
  end

endmodule

`default_nettype wire

//--- ex_stage/ex_branch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module ex_branch_unit
  import ex_pkg::*;
(
  input  logic [31:0] pc_i,
  input  logic [31:0] branch_imm_i,
  input  instr_meta_t instr_meta_i,
  input  logic        cmp_result_i,
  input  cpuctrl_t    cpuctrl_i,
  output logic        branch_taken_o,
  output logic [31:0] branch_target_o
);

  ////////////////////////////////////////////////////////////
  // Target candidates
  ////////////////////////////////////////////////////////////

  logic [31:0] jump_target;
  logic [31:0] fallthrough_target;

  assign jump_target = pc_i + branch_imm_i;

  // A dummy instruction does not advance the pc, so it falls through to itself
  always_comb begin
    if (instr_meta_i.dummy) begin
      fallthrough_target = pc_i;
    end else if (instr_meta_i.compressed) begin
      fallthrough_target = pc_i + PC_INC_COMPRESSED;
    end else begin
      fallthrough_target = pc_i + PC_INC_FULL;
    end
  end

  ////////////////////////////////////////////////////////////
  // Decision
  ////////////////////////////////////////////////////////////

  // With data-independent timing every branch redirects the fetch
  // An untaken branch then redirects to its own fall-through address,
  // so taken and untaken branches cost the same number of cycles
  always_comb begin
    if (cpuctrl_i.dataindtiming) begin
      branch_taken_o  = 1'b1;
      branch_target_o = cmp_result_i ? jump_target : fallthrough_target;
    end else begin
      // Normal mode only redirects when the compare holds
      branch_taken_o  = cmp_result_i;
      branch_target_o = jump_target;
    end
  end

endmodule

`default_nettype wire

//--- ex_stage/ex_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ex_stage
  import ex_pkg::*;
(
  input  logic        clk,
  input  logic        reset_i,

  input  logic        id_valid_i,
  input  id_ex_pipe_t id_ex_pipe_i,
  output logic        ex_ready_o,

  input  ctrl_fsm_t   ctrl_fsm_i,
  input  cpuctrl_t    cpuctrl_i,

  input  logic        wb_ready_i,
  output logic        ex_valid_o,
  output ex_wb_pipe_t ex_wb_pipe_o,

  output logic        branch_valid_o,
  output logic        branch_taken_o,
  output logic [31:0] branch_target_o
);

  ////////////////////////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////////////////////////

  id_ex_pipe_t id_ex_q;
  logic        instr_valid_q;

  // Kill always frees the stage, halt freezes it
  // Otherwise EX can take a new instruction when it is empty or its
  // current one moves on to WB in this cycle
  assign ex_ready_o = ctrl_fsm_i.kill_ex ||
                      (!ctrl_fsm_i.halt_ex && (!instr_valid_q || wb_ready_i));

  assign ex_valid_o = instr_valid_q && !ctrl_fsm_i.halt_ex && !ctrl_fsm_i.kill_ex;

  // A kill flushes the stage, including anything ID offers in the same cycle,
  // since the younger stages are flushed together with EX
  always_ff @(posedge clk) begin
    if (reset_i) begin
      instr_valid_q <= 1'b0;
    end else if (ctrl_fsm_i.kill_ex) begin
      instr_valid_q <= 1'b0;
    end else if (ex_ready_o) begin
      instr_valid_q <= id_valid_i;
    end
  end

  // Payload is loaded only on a real transfer
  always_ff @(posedge clk) begin
    if (ex_ready_o && id_valid_i) begin
      id_ex_q <= id_ex_pipe_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Functional units
  ////////////////////////////////////////////////////////////

  logic [31:0] alu_result;
  logic        alu_cmp_result;

  ex_alu i_ex_alu (
    .operand_a_i  (id_ex_q.operand_a),
    .operand_b_i  (id_ex_q.operand_b),
    .alu_op_i     (id_ex_q.alu_op),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  ex_branch_unit i_ex_branch_unit (
    .pc_i            (id_ex_q.pc),
    .branch_imm_i    (id_ex_q.branch_imm),
    .instr_meta_i    (id_ex_q.instr_meta),
    .cmp_result_i    (alu_cmp_result),
    .cpuctrl_i       (cpuctrl_i),
    .branch_taken_o  (branch_taken_o),
    .branch_target_o (branch_target_o)
  );

  // The branch result is only meaningful while the entry can leave EX
  assign branch_valid_o = ex_valid_o && id_ex_q.instr_meta.branch;

  ////////////////////////////////////////////////////////////
  // CSR legality
  ////////////////////////////////////////////////////////////

  logic csr_impl;
  logic csr_illegal;
  logic lsu_split_first;

  always_comb begin
    csr_impl = 1'b0;
    for (int i = 0; i < CSR_NUM_IMPL; i++) begin
      if (id_ex_q.csr_addr == CSR_IMPL_ADDRS[i]) begin
        csr_impl = 1'b1;
      end
    end
  end

  // Writing a read-only CSR is as illegal as writing a missing one
  assign csr_illegal = !csr_impl || (id_ex_q.csr_addr[11:10] == CSR_RO_MARK);

  // Decode flags the first half of a split load/store through sys_en
  assign lsu_split_first = id_ex_q.lsu_en && id_ex_q.sys_en;

  ////////////////////////////////////////////////////////////
  // Writeback payload
  ////////////////////////////////////////////////////////////

  always_comb begin
    ex_wb_pipe_o.rd       = id_ex_q.rd;
    ex_wb_pipe_o.rf_wdata = id_ex_q.alu_en ? alu_result : id_ex_q.operand_a;
    // The second half of a split access carries the register write
    ex_wb_pipe_o.rf_we    = id_ex_q.rf_we && !lsu_split_first;
    // An accepted coprocessor instruction owns the CSR side effect, so the
    // pipeline drops its own CSR write
    ex_wb_pipe_o.csr_en    = id_ex_q.csr_en && !csr_illegal && !id_ex_q.xif_accepted;
    ex_wb_pipe_o.csr_addr  = id_ex_q.csr_addr;
    ex_wb_pipe_o.csr_wdata = id_ex_q.operand_a;
    ex_wb_pipe_o.lsu_en    = id_ex_q.lsu_en;
  end

endmodule

`default_nettype wire

//--- rv_ex.f
common/ex_pkg.sv
ex_stage/ex_alu.sv
ex_stage/ex_branch_unit.sv
ex_stage/ex_stage.sv
src/wb_stage.sv
src/ex_subsys_top.sv
dv/ex_checker.sv
dv/ex_tb.sv

//--- src/ex_subsys_top.sv
`timescale 1ns/100ps
`default_nettype none

module ex_subsys_top
  import ex_pkg::*;
(
  input  logic        clk,
  input  logic        reset_i,

  input  logic        id_valid_i,
  input  id_ex_pipe_t id_ex_pipe_i,
  output logic        ex_ready_o,

  input  ctrl_fsm_t   ctrl_fsm_i,
  input  cpuctrl_t    cpuctrl_i,
  input  logic        wb_stall_i,

  output logic        branch_valid_o,
  output logic        branch_taken_o,
  output logic [31:0] branch_target_o,

  output logic        rf_we_o,
  output logic [4:0]  rf_waddr_o,
  output logic [31:0] rf_wdata_o,
  output logic        csr_we_o,
  output logic [11:0] csr_addr_o,
  output logic [31:0] csr_wdata_o
);

  // EX to WB handshake and payload
  logic        ex_valid;
  logic        wb_ready;
  ex_wb_pipe_t ex_wb_pipe;

  ex_stage i_ex_stage (
    .clk             (clk),
    .reset_i         (reset_i),
    .id_valid_i      (id_valid_i),
    .id_ex_pipe_i    (id_ex_pipe_i),
    .ex_ready_o      (ex_ready_o),
    .ctrl_fsm_i      (ctrl_fsm_i),
    .cpuctrl_i       (cpuctrl_i),
    .wb_ready_i      (wb_ready),
    .ex_valid_o      (ex_valid),
    .ex_wb_pipe_o    (ex_wb_pipe),
    .branch_valid_o  (branch_valid_o),
    .branch_taken_o  (branch_taken_o),
    .branch_target_o (branch_target_o)
  );

  wb_stage i_wb_stage (
    .clk          (clk),
    .reset_i      (reset_i),
    .ex_valid_i   (ex_valid),
    .ex_wb_pipe_i (ex_wb_pipe),
    .wb_stall_i   (wb_stall_i),
    .wb_ready_o   (wb_ready),
    .rf_we_o      (rf_we_o),
    .rf_waddr_o   (rf_waddr_o),
    .rf_wdata_o   (rf_wdata_o),
    .csr_we_o     (csr_we_o),
    .csr_addr_o   (csr_addr_o),
    .csr_wdata_o  (csr_wdata_o)
  );

endmodule

`default_nettype wire

//--- src/wb_stage.sv
`timescale 1ns/100ps
`default_nettype none

module wb_stage
  import ex_pkg::*;
(
  input  logic        clk,
  input  logic        reset_i,
  input  logic        ex_valid_i,
  input  ex_wb_pipe_t ex_wb_pipe_i,
  input  logic        wb_stall_i,
  output logic        wb_ready_o,
  output logic        rf_we_o,
  output logic [4:0]  rf_waddr_o,
  output logic [31:0] rf_wdata_o,
  output logic        csr_we_o,
  output logic [11:0] csr_addr_o,
  output logic [31:0] csr_wdata_o
);

  ex_wb_pipe_t ex_wb_q;
  logic        wb_valid_q;

  // The entry retires in every cycle without stall, which frees the slot
  // for the next instruction on the same edge
  assign wb_ready_o = !wb_valid_q || !wb_stall_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wb_valid_q <= 1'b0;
    end else if (wb_ready_o) begin
      wb_valid_q <= ex_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_ready_o && ex_valid_i) begin
      ex_wb_q <= ex_wb_pipe_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Write ports
  ////////////////////////////////////////////////////////////

  // Strobes fire only in the retiring cycle
  assign rf_we_o    = wb_valid_q && ex_wb_q.rf_we && !wb_stall_i;
  assign rf_waddr_o = ex_wb_q.rd;
  assign rf_wdata_o = ex_wb_q.rf_wdata;

  assign csr_we_o    = wb_valid_q && ex_wb_q.csr_en && !wb_stall_i;
  assign csr_addr_o  = ex_wb_q.csr_addr;
  assign csr_wdata_o = ex_wb_q.csr_wdata;

endmodule

`default_nettype wire
